/* rtl/cc_attach_detect.sv */
// CC line debouncer with attach and polarity detection
`timescale 1ns/1ps

module cc_attach_detect import usb_pd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cc1_in,
    input  logic       cc2_in,
    output logic       attached,
    output logic [1:0] polarity
);

    logic [1:0]           cc_in;
    logic [1:0]           sample_q;             // Last raw sample per line
    logic [DEB_CNT_W-1:0] stable_cnt_q [2];     // Equal samples seen per line
    logic [1:0]           level_q;              // Accepted line levels
    logic [1:0]           level_d;

    assign cc_in = {cc2_in, cc1_in};            // Bit 0 is CC1

    // A line is accepted once its sample has held for the full debounce window
    always_comb begin
        level_d = level_q;
        for (int i = 0; i < 2; i++) begin
            if (cc_in[i] == sample_q[i] &&
                stable_cnt_q[i] == DEB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                level_d[i] = sample_q[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_q <= '0;
            level_q  <= '0;
            polarity <= 2'b00;
            for (int i = 0; i < 2; i++) begin
                stable_cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cc_in[i] != sample_q[i]) begin
                    sample_q[i]     <= cc_in[i];   // Restart the window
                    stable_cnt_q[i] <= '0;
                end else if (stable_cnt_q[i] != DEB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    stable_cnt_q[i] <= stable_cnt_q[i] + 1'b1;
                end
            end
            level_q <= level_d;
            case (level_d)
                2'b01:   polarity <= 2'b01;        // CC1 pulled
                2'b10:   polarity <= 2'b10;        // CC2 pulled
                2'b00:   polarity <= 2'b00;        // Detached
                default: polarity <= polarity;     // Both high, keep the prior line
            endcase
        end
    end

    assign attached = |level_q;

endmodule

/* rtl/pd_policy_engine.sv */
// Source policy engine FSM with CC transmit drive and contract latch
`timescale 1ns/1ps

module pd_policy_engine import usb_pd_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 attached,
    input  logic [1:0]           polarity,
    input  logic                 pd_negotiation_start,
    input  logic                 sink_request,
    input  logic [OBJ_POS_W-1:0] sink_obj_pos,
    input  logic [PDO_W-1:0]     pos_pdo,
    input  logic                 pos_valid,
    output logic [OBJ_POS_W-1:0] req_pos,
    output logic                 busy,
    output logic                 cc1_out,
    output logic                 cc2_out,
    output logic                 cc1_oe,
    output logic                 cc2_oe,
    output pd_state_e            pd_state,
    output logic [PDO_W-1:0]     selected_pdo,
    output logic                 pd_contract_established
);

    pd_state_e          state_q;
    logic [PHASE_W-1:0] phase_q;         // Shared by SRC_CAP and ACCEPT
    logic               active_cc2_q;    // Line latched at start, 1 selects CC2
    logic               tx_bit_q;        // Preamble bit
    logic               tx_active;

    assign tx_active = (state_q == SRC_CAP) || (state_q == ACCEPT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q                 <= IDLE;
            phase_q                 <= '0;
            active_cc2_q            <= 1'b0;
            selected_pdo            <= '0;
            pd_contract_established <= 1'b0;
        end else if (!attached) begin
            // Detach abandons any contract in progress
            state_q                 <= IDLE;
            phase_q                 <= '0;
            selected_pdo            <= '0;
            pd_contract_established <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (pd_negotiation_start) begin
                        state_q      <= SRC_CAP;
                        phase_q      <= '0;
                        active_cc2_q <= (polarity == 2'b10);
                    end
                end
                SRC_CAP: begin
                    if (phase_q == PHASE_W'(SRC_CAP_CYCLES - 1)) begin
                        state_q <= REQUEST;
                        phase_q <= '0;
                    end else begin
                        phase_q <= phase_q + 1'b1;
                    end
                end
                REQUEST: begin
                    if (sink_request) begin
                        phase_q <= '0;
                        if (pos_valid) begin
                            state_q      <= ACCEPT;
                            selected_pdo <= pos_pdo;
                        end else begin
                            state_q <= SRC_CAP;   // Resend the capabilities
                        end
                    end
                end
                ACCEPT: begin
                    // Supply settle time before PS_RDY
                    if (phase_q == PHASE_W'(ACCEPT_CYCLES - 1)) begin
                        state_q                 <= PS_RDY;
                        phase_q                 <= '0;
                        pd_contract_established <= 1'b1;
                    end else begin
                        phase_q <= phase_q + 1'b1;
                    end
                end
                PS_RDY: begin
                    pd_contract_established <= 1'b1;  // Held until detach
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Alternating preamble, restarts from 0 on each transmit state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_bit_q <= 1'b0;
        end else if (tx_active) begin
            tx_bit_q <= ~tx_bit_q;
        end else begin
            tx_bit_q <= 1'b0;
        end
    end

    assign cc1_oe  = tx_active && !active_cc2_q;
    assign cc2_oe  = tx_active && active_cc2_q;
    assign cc1_out = cc1_oe && tx_bit_q;
    assign cc2_out = cc2_oe && tx_bit_q;

    assign busy     = (state_q != IDLE);
    assign req_pos  = sink_obj_pos;       // Register block checks the range
    assign pd_state = state_q;

endmodule

/* rtl/pdo_config_regs.sv */
// Source PDO register block with count register and object position lookup
`timescale 1ns/1ps

module pdo_config_regs import usb_pd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_we,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [PDO_W-1:0]      cfg_wdata,
    input  logic                  busy,
    input  logic [OBJ_POS_W-1:0]  req_pos,
    output logic [PDO_W-1:0]      pos_pdo,
    output logic                  pos_valid,
    output logic [OBJ_POS_W-1:0]  pdo_count
);

    logic [PDO_W-1:0]     pdo_q [MAX_PDOS];
    logic [OBJ_POS_W-1:0] count_q;
    logic [SLOT_W-1:0]    slot;
    logic                 wr_en;

    // Table is frozen while a negotiation is running
    assign wr_en = cfg_we && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            for (int i = 0; i < MAX_PDOS; i++) begin
                pdo_q[i] <= '0;
            end
        end else if (wr_en) begin
            if (cfg_addr == CFG_COUNT_ADDR) begin
                count_q <= cfg_wdata[OBJ_POS_W-1:0];   // Count lives in the low bits
            end else if (cfg_addr < CFG_ADDR_W'(MAX_PDOS)) begin
                pdo_q[cfg_addr[SLOT_W-1:0]] <= cfg_wdata;
            end
        end
    end

    // Object positions are one based
    assign slot = SLOT_W'(req_pos - OBJ_POS_W'(1));

    assign pos_pdo   = pdo_q[slot];
    assign pos_valid = (req_pos != '0) &&
                       (req_pos <= count_q) &&
                       (count_q <= OBJ_POS_W'(MAX_PDOS));  // Reject an oversized count
    assign pdo_count = count_q;

endmodule

/* rtl/usb_pd_pkg.sv */
// USB PD source package with state encoding, widths and timing constants
package usb_pd_pkg;

    // Power data objects
    localparam int PDO_W     = 32;
    localparam int MAX_PDOS  = 4;
    localparam int OBJ_POS_W = 3;                  // Position 0 is invalid
    localparam int SLOT_W    = $clog2(MAX_PDOS);

    // Configuration address map
    localparam int CFG_ADDR_W = 3;
    localparam logic [CFG_ADDR_W-1:0] CFG_COUNT_ADDR = 3'd4;   // Slots sit at 0 to 3

    // CC debounce
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEB_CNT_W       = $clog2(DEBOUNCE_CYCLES);

    // Negotiation timing in clock cycles
    localparam int SRC_CAP_CYCLES = 11;
    localparam int ACCEPT_CYCLES  = 6;
    localparam int PHASE_W        = $clog2(SRC_CAP_CYCLES);  // Longer of the two phases

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        SRC_CAP = 3'd1,
        REQUEST = 3'd2,
        ACCEPT  = 3'd3,
        PS_RDY  = 3'd4
    } pd_state_e;

endpackage

/* rtl/usb_pd_source.sv */
// USB PD source top with attach detector, PDO registers and policy engine
`timescale 1ns/1ps

module usb_pd_source import usb_pd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cc1_in,
    input  logic                  cc2_in,
    input  logic                  pd_negotiation_start,
    input  logic                  cfg_we,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [PDO_W-1:0]      cfg_wdata,
    input  logic                  sink_request,
    input  logic [OBJ_POS_W-1:0]  sink_obj_pos,
    output logic                  cc1_out,
    output logic                  cc2_out,
    output logic                  cc1_oe,
    output logic                  cc2_oe,
    output pd_state_e             pd_state,
    output logic [1:0]            cc_polarity,
    output logic [PDO_W-1:0]      selected_pdo,
    output logic                  pd_contract_established
);

    logic                 attached;
    logic                 busy;
    logic [OBJ_POS_W-1:0] req_pos;
    logic [PDO_W-1:0]     pos_pdo;
    logic                 pos_valid;

    cc_attach_detect i_cc_attach_detect (
        .clk      (clk),
        .rst_n    (rst_n),
        .cc1_in   (cc1_in),
        .cc2_in   (cc2_in),
        .attached (attached),
        .polarity (cc_polarity)
    );

    // Count is for debug only, the engine relies on pos_valid
    pdo_config_regs i_pdo_config_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .busy      (busy),
        .req_pos   (req_pos),
        .pos_pdo   (pos_pdo),
        .pos_valid (pos_valid),
        .pdo_count ()
    );

    pd_policy_engine i_pd_policy_engine (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .attached                (attached),
        .polarity                (cc_polarity),
        .pd_negotiation_start    (pd_negotiation_start),
        .sink_request            (sink_request),
        .sink_obj_pos            (sink_obj_pos),
        .pos_pdo                 (pos_pdo),
        .pos_valid               (pos_valid),
        .req_pos                 (req_pos),
        .busy                    (busy),
        .cc1_out                 (cc1_out),
        .cc2_out                 (cc2_out),
        .cc1_oe                  (cc1_oe),
        .cc2_oe                  (cc2_oe),
        .pd_state                (pd_state),
        .selected_pdo            (selected_pdo),
        .pd_contract_established (pd_contract_established)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the USB PD source testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_usb_pd_source \
    -f usb_pd_source.f -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    || { echo "FAIL: build or simulation aborted"; exit 1; }

grep -q "Test failed" sim.log \
    && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }

/* sim/tb_usb_pd_source.sv */
// Testbench for the USB PD source with a cycle reference model and random negotiations
`timescale 1ns/1ps

module tb_usb_pd_source import usb_pd_pkg::*; ();

    logic                  clk;
    logic                  rst_n;
    logic                  cc1_in;
    logic                  cc2_in;
    logic                  pd_negotiation_start;
    logic                  cfg_we;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [PDO_W-1:0]      cfg_wdata;
    logic                  sink_request;
    logic [OBJ_POS_W-1:0]  sink_obj_pos;
    logic                  cc1_out;
    logic                  cc2_out;
    logic                  cc1_oe;
    logic                  cc2_oe;
    pd_state_e             pd_state;
    logic [1:0]            cc_polarity;
    logic [PDO_W-1:0]      selected_pdo;
    logic                  pd_contract_established;

    // Reference model state
    pd_state_e        m_state;
    int               m_phase;
    logic             m_cc2;                // Active line latched at start
    logic             m_tx;
    logic [PDO_W-1:0] m_pdo [MAX_PDOS];
    int               m_count;
    logic [PDO_W-1:0] m_sel;
    logic             m_contract;
    logic [1:0]       m_last;               // Last sampled CC levels
    int               m_run [2];            // Edges the sampled level has held
    logic [1:0]       m_level;
    logic [1:0]       m_pol;

    usb_pd_source i_usb_pd_source (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic model_step();
        logic       att;
        logic       was_idle;
        logic       valid;
        logic [1:0] cc;
        int         pos;
        att      = |m_level;
        was_idle = (m_state == IDLE);
        cc       = {cc2_in, cc1_in};
        pos      = int'(sink_obj_pos);
        valid    = (pos >= 1) && (pos <= m_count) && (m_count <= MAX_PDOS);
        m_tx     = ((m_state == SRC_CAP) || (m_state == ACCEPT)) ? !m_tx : 1'b0;
        if (!att) begin
            m_state    = IDLE;
            m_sel      = '0;
            m_contract = 1'b0;
        end else begin
            case (m_state)
                IDLE: begin
                    if (pd_negotiation_start) begin
                        m_state = SRC_CAP;
                        m_phase = 0;
                        m_cc2   = (m_pol == 2'b10);
                    end
                end
                SRC_CAP: begin
                    m_phase++;
                    if (m_phase == SRC_CAP_CYCLES) begin
                        m_state = REQUEST;
                    end
                end
                REQUEST: begin
                    m_phase = 0;
                    if (sink_request && valid) begin
                        m_state = ACCEPT;
                        m_sel   = m_pdo[2'(pos - 1)];
                    end else if (sink_request) begin
                        m_state = SRC_CAP;      // Capabilities go out again
                    end
                end
                ACCEPT: begin
                    m_phase++;
                    if (m_phase == ACCEPT_CYCLES) begin
                        m_state    = PS_RDY;
                        m_contract = 1'b1;
                    end
                end
                default: ;
            endcase
        end
        if (cfg_we && was_idle && cfg_addr == CFG_COUNT_ADDR) begin
            m_count = int'(cfg_wdata[2:0]);
        end else if (cfg_we && was_idle && int'(cfg_addr) < MAX_PDOS) begin
            m_pdo[cfg_addr[1:0]] = cfg_wdata;
        end
        // A level is taken once it has been sampled on DEBOUNCE_CYCLES+1 edges
        for (int i = 0; i < 2; i++) begin
            m_run[i]  = (cc[i] == m_last[i]) ? m_run[i] + 1 : 1;
            m_last[i] = cc[i];
            if (m_run[i] > DEBOUNCE_CYCLES) begin
                m_level[i] = m_last[i];
            end
        end
        if (m_level != 2'b11) begin
            m_pol = m_level;                     // Both high keeps the old line
        end
    endtask

    task automatic check_outputs();
        logic tx;
        tx = (m_state == SRC_CAP) || (m_state == ACCEPT);
        check_value("pd_state", 32'(pd_state), 32'(m_state));
        check_value("cc_polarity", 32'(cc_polarity), 32'(m_pol));
        check_value("selected_pdo", selected_pdo, m_sel);
        check_value("pd_contract_established", 32'(pd_contract_established), 32'(m_contract));
        check_value("cc1_oe", 32'(cc1_oe), 32'(tx && !m_cc2));
        check_value("cc2_oe", 32'(cc2_oe), 32'(tx && m_cc2));
        check_value("cc1_out", 32'(cc1_out), 32'(tx && !m_cc2 && m_tx));
        check_value("cc2_out", 32'(cc2_out), 32'(tx && m_cc2 && m_tx));
    endtask

    // One clock: model update at the edge, compare, then drive the next inputs
    task automatic step_cycle();
        @(posedge clk);
        model_step();
        #1;
        check_outputs();
        cfg_we    = (m_state != IDLE) && ($urandom_range(0, 3) == 0);   // Blocked by busy
        cfg_addr  = CFG_ADDR_W'($urandom_range(0, 4));
        cfg_wdata = $urandom;
    endtask

    task automatic wait_state(input pd_state_e target, input int limit, output int cycles);
        cycles = 0;
        while (pd_state != target) begin
            if (cycles == limit) begin
                $display("Timeout after %0d cycles waiting for %s", limit, target.name());
                abort_run();
            end else begin
                step_cycle();
                cycles++;
            end
        end
    endtask

    task automatic wait_polarity(input logic [1:0] pol);
        int n;
        n = 0;
        while (cc_polarity != pol) begin
            if (n == DEBOUNCE_CYCLES + 4) begin
                $display("Timeout waiting for CC polarity %b", pol);
                abort_run();
            end else begin
                step_cycle();
                n++;
            end
        end
    endtask

    task automatic send_request(input int pos);
        sink_request = 1'b1;
        sink_obj_pos = OBJ_POS_W'(pos);
        step_cycle();
        sink_request = 1'b0;
    endtask

    task automatic configure();
        for (int i = 0; i < MAX_PDOS; i++) begin
            cfg_we    = 1'b1;
            cfg_addr  = CFG_ADDR_W'(i);
            cfg_wdata = $urandom;
            step_cycle();
        end
        cfg_we         = 1'b1;
        cfg_addr       = CFG_COUNT_ADDR;
        cfg_wdata      = $urandom;
        cfg_wdata[2:0] = 3'($urandom_range(1, MAX_PDOS));
        step_cycle();
    endtask

    task automatic negotiate();
        int               n;
        int               pos;
        logic [1:0]       pol;
        logic [PDO_W-1:0] exp_pdo;
        pol = ($urandom_range(0, 1) == 0) ? 2'b01 : 2'b10;
        configure();
        cc1_in = pol[0];
        cc2_in = pol[1];
        wait_polarity(pol);
        pd_negotiation_start = 1'b1;
        wait_state(SRC_CAP, 2, n);
        pd_negotiation_start = 1'b0;
        if ($urandom_range(0, 3) == 0) begin
            // Random requests, then detach wherever the engine is
            repeat ($urandom_range(0, 30)) begin
                sink_request = ($urandom_range(0, 3) == 0);
                sink_obj_pos = OBJ_POS_W'($urandom_range(0, 7));
                step_cycle();
            end
            sink_request = 1'b0;
        end else begin
            wait_state(REQUEST, SRC_CAP_CYCLES + 2, n);
            check_value("SRC_CAP length", 32'(n), 32'(SRC_CAP_CYCLES));
            if ($urandom_range(0, 2) == 0) begin
                pos = ($urandom_range(0, 1) == 0) ? 0 : int'($urandom_range(m_count + 1, 7));
                send_request(pos);
                check_value("pd_state", 32'(pd_state), 32'(SRC_CAP));
                check_value("selected_pdo", selected_pdo, 32'h0);
                wait_state(REQUEST, SRC_CAP_CYCLES + 2, n);
                check_value("SRC_CAP length", 32'(n), 32'(SRC_CAP_CYCLES));
            end
            pos     = int'($urandom_range(1, m_count));
            exp_pdo = m_pdo[2'(pos - 1)];
            send_request(pos);
            wait_state(PS_RDY, ACCEPT_CYCLES + 2, n);
            check_value("ACCEPT length", 32'(n), 32'(ACCEPT_CYCLES));
            check_value("selected_pdo", selected_pdo, exp_pdo);
            check_value("pd_contract_established", 32'(pd_contract_established), 32'h1);
            repeat ($urandom_range(0, 5)) step_cycle();
        end
        cc1_in = 1'b0;
        cc2_in = 1'b0;
        wait_state(IDLE, DEBOUNCE_CYCLES + 4, n);
        check_value("detach delay", 32'(n), 32'(DEBOUNCE_CYCLES + 2));
        check_value("selected_pdo", selected_pdo, 32'h0);
    endtask

    initial begin
        void'($urandom(32'h4815_f930));
        rst_n                = 1'b0;
        cc1_in               = 1'b0;
        cc2_in               = 1'b0;
        pd_negotiation_start = 1'b0;
        cfg_we               = 1'b0;
        cfg_addr             = '0;
        cfg_wdata            = '0;
        sink_request         = 1'b0;
        sink_obj_pos         = '0;
        m_state              = IDLE;
        m_phase              = 0;
        m_cc2                = 1'b0;
        m_tx                 = 1'b0;
        m_pdo                = '{default: '0};
        m_count              = 0;
        m_sel                = '0;
        m_contract           = 1'b0;
        m_last               = 2'b00;
        m_run                = '{1, 1};
        m_level              = 2'b00;
        m_pol                = 2'b00;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_outputs();
        pd_negotiation_start = 1'b1;             // Must not start on a glitch
        repeat (40) begin
            if ($urandom_range(0, 1) == 0) begin
                cc1_in = 1'b1;
            end else begin
                cc2_in = 1'b1;
            end
            repeat ($urandom_range(1, DEBOUNCE_CYCLES - 1)) step_cycle();
            cc1_in = 1'b0;
            cc2_in = 1'b0;
            repeat ($urandom_range(1, 4)) step_cycle();
            check_value("cc_polarity", 32'(cc_polarity), 32'h0);
            check_value("pd_state", 32'(pd_state), 32'(IDLE));
        end
        pd_negotiation_start = 1'b0;
        repeat (300) negotiate();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* sim/usb_pd_source_sva.sv */
// Bound assertions on policy engine state, CC drive and contract flag
`timescale 1ns/1ps

module usb_pd_source_sva import usb_pd_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input pd_state_e pd_state,
    input logic      cc1_oe,
    input logic      cc2_oe,
    input logic      pd_contract_established
);

    // Drive only while a message is on the line
    oe_in_tx_state: assert property (@(posedge clk) disable iff (!rst_n)
        (cc1_oe || cc2_oe) |-> (pd_state == SRC_CAP || pd_state == ACCEPT))
        else $error("CC output enabled in state %0d", pd_state);

    oe_one_line: assert property (@(posedge clk) disable iff (!rst_n)
        !(cc1_oe && cc2_oe))
        else $error("Both CC outputs enabled");

    contract_in_ps_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        pd_contract_established == (pd_state == PS_RDY))
        else $error("Contract flag %b in state %0d", pd_contract_established, pd_state);

endmodule

bind pd_policy_engine usb_pd_source_sva i_usb_pd_source_sva (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .pd_state                (pd_state),
    .cc1_oe                  (cc1_oe),
    .cc2_oe                  (cc2_oe),
    .pd_contract_established (pd_contract_established)
);

/* usb_pd_source.f */
rtl/usb_pd_pkg.sv
rtl/cc_attach_detect.sv
rtl/pdo_config_regs.sv
rtl/pd_policy_engine.sv
rtl/usb_pd_source.sv
sim/usb_pd_source_sva.sv
sim/tb_usb_pd_source.sv
